//--- src/aes_pkg.sv
package aes_pkg;

  // ----------------------------------------
  // Widths
  // ----------------------------------------
  localparam int BLOCK_W = 128;
  localparam int WORD_W  = 32;
  localparam int BYTE_W  = 8;

  // Full AES state or one round key, word 0 in the top bits
  typedef logic [BLOCK_W-1:0] block_t;
  // One state column
  typedef logic [WORD_W-1:0]  word_t;
  // One state byte
  typedef logic [BYTE_W-1:0]  byte_t;
  // Round index, also the key store address
  typedef logic [3:0]         round_t;
  // Selects one of the four state words
  typedef logic [1:0]         word_idx_t;

  // ----------------------------------------
  // Round counts and field constants
  // ----------------------------------------
  localparam round_t AES128_ROUNDS = 4'd10;
  localparam round_t AES256_ROUNDS = 4'd14;

  // Low byte of x^8 + x^4 + x^3 + x + 1
  localparam byte_t GF_POLY       = 8'h1b;
  // Constant of the S-box affine map
  localparam byte_t SBOX_AFFINE_C = 8'h63;

  // Kind of write into the state words
  typedef enum logic [2:0] {
    UPD_NONE  = 3'd0,
    UPD_INIT  = 3'd1,
    UPD_SBOX  = 3'd2,
    UPD_MAIN  = 3'd3,
    UPD_FINAL = 3'd4
  } update_e;

  // Encipher FSM states
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_INIT = 2'd1,
    ST_SBOX = 2'd2,
    ST_MAIN = 2'd3
  } enc_state_e;

  // Multiply by x in GF(2^8)
  function automatic byte_t xtime(input byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? GF_POLY : 8'h00);
  endfunction

endpackage

//--- src/aes_sbox_word.sv
`timescale 1ns/100ps

module aes_sbox_word (
  input  aes_pkg::word_t word_in,
  output aes_pkg::word_t word_out
);
  import aes_pkg::*;

  // ----------------------------------------
  // GF(2^8) arithmetic
  // ----------------------------------------
  // Shift and add product, reduced by xtime
  function automatic byte_t gf_mul(input byte_t a, input byte_t b);
    byte_t acc;
    byte_t aa;
    acc = '0;
    aa  = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ aa;
      end
      aa = xtime(aa);
    end
    return acc;
  endfunction

  // Inverse as a^254, zero stays zero
  function automatic byte_t gf_inv(input byte_t a);
    byte_t x2;
    byte_t x3;
    byte_t x6;
    byte_t x12;
    byte_t x15;
    byte_t x30;
    byte_t x60;
    byte_t x120;
    byte_t x240;
    x2   = gf_mul(a, a);
    x3   = gf_mul(x2, a);
    x6   = gf_mul(x3, x3);
    x12  = gf_mul(x6, x6);
    x15  = gf_mul(x12, x3);
    x30  = gf_mul(x15, x15);
    x60  = gf_mul(x30, x30);
    x120 = gf_mul(x60, x60);
    x240 = gf_mul(x120, x120);
    // 240 + 12 + 2
    return gf_mul(gf_mul(x240, x12), x2);
  endfunction

  // Affine map, b ^ rotl1 ^ rotl2 ^ rotl3 ^ rotl4 ^ 63
  function automatic byte_t affine(input byte_t b);
    return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
             ^ {b[3:0], b[7:4]} ^ SBOX_AFFINE_C;
  endfunction

  // ----------------------------------------
  // Four byte lanes
  // ----------------------------------------
  for (genvar b = 0; b < 4; b++) begin : g_lane
    assign word_out[8*b +: 8] = affine(gf_inv(word_in[8*b +: 8]));
  end

endmodule

//--- src/aes_mixcolumns.sv
`timescale 1ns/100ps

module aes_mixcolumns (
  input  aes_pkg::block_t state_in,
  output aes_pkg::block_t state_out
);
  import aes_pkg::*;

  // One column times the fixed matrix
  // rows are 2 3 1 1 rotated right per row
  function automatic word_t mix_column(input word_t col);
    byte_t a0;
    byte_t a1;
    byte_t a2;
    byte_t a3;
    byte_t b0;
    byte_t b1;
    byte_t b2;
    byte_t b3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    // Times 3 is xtime plus the byte itself
    b0 = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
    b1 = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
    b2 = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
    b3 = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
    return {b0, b1, b2, b3};
  endfunction

  // ----------------------------------------
  // Columns are independent
  // ----------------------------------------
  for (genvar c = 0; c < 4; c++) begin : g_col
    assign state_out[127 - 32*c -: 32] = mix_column(state_in[127 - 32*c -: 32]);
  end

endmodule

//--- src/aes_round_ctrl.sv
`timescale 1ns/100ps

module aes_round_ctrl (
  input  logic               iClk,
  input  logic               arst_n,
  input  logic               next,
  input  logic               keylen,
  output aes_pkg::update_e   update,
  output aes_pkg::word_idx_t sword_idx,
  output aes_pkg::round_t    round,
  output logic               ready
);
  import aes_pkg::*;

  // ----------------------------------------
  // Control state
  // ----------------------------------------
  enc_state_e state_q;
  enc_state_e state_d;
  round_t     round_q;
  round_t     round_d;
  word_idx_t  sword_q;
  word_idx_t  sword_d;

  // Number of rounds for the selected key length
  round_t     num_rounds;
  // High while main rounds remain before the final one
  logic       more_rounds;

  assign num_rounds  = keylen ? AES256_ROUNDS : AES128_ROUNDS;
  assign more_rounds = (round_q < num_rounds);

  // ----------------------------------------
  // Next state and update kind
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    round_d = round_q;
    // Word counter restarts outside the S-box phase
    sword_d = '0;
    update  = UPD_NONE;
    case (state_q)
      ST_IDLE: begin
        // Start only accepted here, so next is ignored while busy
        if (next) begin
          round_d = '0;
          state_d = ST_INIT;
        end
      end
      ST_INIT: begin
        // Initial AddRoundKey with round key 0
        update  = UPD_INIT;
        round_d = round_q + 4'd1;
        state_d = ST_SBOX;
      end
      ST_SBOX: begin
        // One word through the S-boxes per cycle
        update  = UPD_SBOX;
        sword_d = sword_q + 2'd1;
        if (sword_q == 2'd3) begin
          state_d = ST_MAIN;
        end
      end
      ST_MAIN: begin
        if (more_rounds) begin
          update  = UPD_MAIN;
          round_d = round_q + 4'd1;
          state_d = ST_SBOX;
        end else begin
          // Last round skips MixColumns, round index holds at Nr
          update  = UPD_FINAL;
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  // ----------------------------------------
  // Registers
  // ----------------------------------------
  always_ff @(posedge iClk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= ST_IDLE;
      round_q <= '0;
      sword_q <= '0;
    end else begin
      state_q <= state_d;
      round_q <= round_d;
      sword_q <= sword_d;
    end
  end

  // Outputs straight from the state
  assign ready     = (state_q == ST_IDLE);
  assign round     = round_q;
  assign sword_idx = sword_q;

endmodule

//--- src/aes_round_datapath.sv
`timescale 1ns/100ps

module aes_round_datapath (
  input  logic               iClk,
  input  aes_pkg::update_e   update,
  input  aes_pkg::word_idx_t sword_idx,
  input  aes_pkg::block_t    block,
  input  aes_pkg::block_t    round_key,
  output aes_pkg::block_t    new_block
);
  import aes_pkg::*;

  // ----------------------------------------
  // State words and derived views
  // ----------------------------------------
  // Word 0 is the first column, bits 127:96 of the block
  word_t  state_q [4];
  block_t state_blk;
  block_t shift_blk;
  block_t mix_blk;
  word_t  sbox_in;
  word_t  sbox_out;
  block_t block_nxt;
  logic [3:0] word_we;

  assign state_blk = {state_q[0], state_q[1], state_q[2], state_q[3]};

  // ShiftRows
  // row r of column c comes from column c+r
  always_comb begin
    shift_blk = '0;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shift_blk[127 - 32*c - 8*r -: 8] = state_q[(c + r) % 4][31 - 8*r -: 8];
      end
    end
  end

  aes_mixcolumns u_mixcolumns (
    .state_in  (shift_blk),
    .state_out (mix_blk)
  );

  // Word picked for substitution this cycle
  assign sbox_in = state_q[sword_idx];

  aes_sbox_word u_sbox_word (
    .word_in  (sbox_in),
    .word_out (sbox_out)
  );

  // ----------------------------------------
  // Update selection
  // ----------------------------------------
  always_comb begin
    block_nxt = shift_blk ^ round_key;
    word_we   = '0;
    case (update)
      UPD_INIT: begin
        block_nxt = block ^ round_key;
        word_we   = 4'hf;
      end
      UPD_SBOX: begin
        // Same word on every lane, only one lane written
        block_nxt          = {4{sbox_out}};
        word_we[sword_idx] = 1'b1;
      end
      UPD_MAIN: begin
        block_nxt = mix_blk ^ round_key;
        word_we   = 4'hf;
      end
      UPD_FINAL: begin
        block_nxt = shift_blk ^ round_key;
        word_we   = 4'hf;
      end
      default: begin
        word_we = '0;
      end
    endcase
  end

  // State word registers, payload only
  always_ff @(posedge iClk) begin
    for (int i = 0; i < 4; i++) begin
      if (word_we[i]) begin
        state_q[i] <= block_nxt[127 - 32*i -: 32];
      end
    end
  end

  // Holds the ciphertext once the FSM is back in idle
  assign new_block = state_blk;

endmodule

//--- src/aes_encipher_core.sv
`timescale 1ns/100ps

module aes_encipher_core (
  input  logic            iClk,
  input  logic            arst_n,
  input  logic            next,
  input  logic            keylen,
  input  aes_pkg::block_t block,
  input  aes_pkg::block_t round_key,
  output aes_pkg::round_t round,
  output aes_pkg::block_t new_block,
  output logic            ready
);
  import aes_pkg::*;

  // ----------------------------------------
  // Control to datapath
  // ----------------------------------------
  update_e   update;
  word_idx_t sword_idx;

  // FSM, round and word counters
  aes_round_ctrl u_ctrl (
    .iClk      (iClk),
    .arst_n    (arst_n),
    .next      (next),
    .keylen    (keylen),
    .update    (update),
    .sword_idx (sword_idx),
    .round     (round),
    .ready     (ready)
  );

  // State words, S-boxes, ShiftRows and MixColumns
  aes_round_datapath u_datapath (
    .iClk      (iClk),
    .update    (update),
    .sword_idx (sword_idx),
    .block     (block),
    .round_key (round_key),
    .new_block (new_block)
  );

endmodule

//--- sim/aes_encipher_sva.sv
`timescale 1ns/100ps

module aes_encipher_sva (
  input logic            iClk,
  input logic            arst_n,
  input logic            next,
  input logic            keylen,
  input aes_pkg::round_t round,
  input aes_pkg::block_t new_block,
  input logic            ready
);
  import aes_pkg::*;

  // ----------------------------------------
  // Tracking of the block in flight
  // ----------------------------------------
  // Number of failed assertions
  int unsigned fail_count = 0;
  // Set by the first accepted start
  logic       started;
  // Key length latched at the accepting edge
  logic       kl_q;
  // Edges since the accepting edge while busy
  logic [6:0] busy_cnt;
  // Round count for the latched key length
  round_t     nr;
  // 1 + 5*Nr edges from start to ready
  logic [6:0] run_len;

  assign nr      = kl_q ? 4'd14 : 4'd10;
  assign run_len = kl_q ? 7'd71 : 7'd51;

  always_ff @(posedge iClk or negedge arst_n) begin
    if (!arst_n) begin
      started  <= 1'b0;
      kl_q     <= 1'b0;
      busy_cnt <= '0;
    end else if (next && ready) begin
      started  <= 1'b1;
      kl_q     <= keylen;
      busy_cnt <= '0;
    end else if (!ready) begin
      busy_cnt <= busy_cnt + 7'd1;
    end
  end

  // ----------------------------------------
  // Assertions
  // ----------------------------------------
  // Idle with round 0 until the first start
  a_reset_idle: assert property (@(posedge iClk) disable iff (!arst_n)
    !started |-> (ready && round == 4'd0))
    else begin
      $error("DUT was not idle at round 0 before the first start");
      fail_count++;
    end

  // Busy no longer than 1 + 5*Nr edges
  a_busy_len: assert property (@(posedge iClk) disable iff (!arst_n)
    !ready |-> busy_cnt < run_len)
    else begin
      $error("ready stayed low past the expected run length");
      fail_count++;
    end

  // ready returns exactly at 1 + 5*Nr edges
  a_ready_edge: assert property (@(posedge iClk) disable iff (!arst_n)
    (started && $rose(ready)) |-> busy_cnt == run_len)
    else begin
      $error("ready rose after the wrong number of edges");
      fail_count++;
    end

  // Round index within the key length's round count
  a_round_max: assert property (@(posedge iClk) disable iff (!arst_n)
    !ready |-> round <= nr)
    else begin
      $error("round index exceeded the round count");
      fail_count++;
    end

  // Ciphertext held while idle
  a_result_hold: assert property (@(posedge iClk) disable iff (!arst_n)
    (started && ready && !next) |=> $stable(new_block))
    else begin
      $error("new_block changed while idle");
      fail_count++;
    end

endmodule

bind aes_encipher_core aes_encipher_sva u_sva (.*);

//--- sim/tb_aes_encipher.sv
`timescale 1ns/100ps

module tb_aes_encipher;
  import aes_pkg::*;

  logic   iClk;
  logic   arst_n;
  logic   next;
  logic   keylen;
  block_t block;
  block_t round_key;
  round_t round;
  block_t new_block;
  logic   ready;

  int errors = 0;
  int cycles = 0;
  int total;

  // ----------------------------------------
  // Key store, FIPS-197 appendix C
  // ----------------------------------------
  block_t keys128 [0:10] = '{
    128'h000102030405060708090a0b0c0d0e0f, 128'hd6aa74fdd2af72fadaa678f1d6ab76fe,
    128'hb692cf0b643dbdf1be9bc5006830b3fe, 128'hb6ff744ed2c2c9bf6c590cbf0469bf41,
    128'h47f7f7bc95353e03f96c32bcfd058dfd, 128'h3caaa3e8a99f9deb50f3af57adf622aa,
    128'h5e390f7df7a69296a7553dc10aa31f6b, 128'h14f9701ae35fe28c440adf4d4ea9c026,
    128'h47438735a41c65b9e016baf4aebf7ad2, 128'h549932d1f08557681093ed9cbe2c974e,
    128'h13111d7fe3944a17f307a78b4d2b30c5};
  block_t keys256 [0:14] = '{
    128'h000102030405060708090a0b0c0d0e0f, 128'h101112131415161718191a1b1c1d1e1f,
    128'ha573c29fa176c498a97fce93a572c09c, 128'h1651a8cd0244beda1a5da4c10640bade,
    128'hae87dff00ff11b68a68ed5fb03fc1567, 128'h6de1f1486fa54f9275f8eb5373b8518d,
    128'hc656827fc9a799176f294cec6cd5598b, 128'h3de23a75524775e727bf9eb45407cf39,
    128'h0bdc905fc27b0948ad5245a4c1871c2f, 128'h45f5a66017b2d387300d4d33640a820a,
    128'h7ccff71cbeb4fe5413e6bbf0d261a7df, 128'hf01afafee7a82979d7a5644ab3afe640,
    128'h2541fe719bf500258813bbd55a721c0a, 128'h4e5a6699a9f24fe07e572baacdf8cdea,
    128'h24fc79ccbf0979e9371ac23c6d68de36};

  // Key store answers the round index combinationally
  assign round_key = keylen ? keys256[round] : keys128[round];

  aes_encipher_core uut (
    .iClk      (iClk),
    .arst_n    (arst_n),
    .next      (next),
    .keylen    (keylen),
    .block     (block),
    .round_key (round_key),
    .round     (round),
    .new_block (new_block),
    .ready     (ready)
  );

  initial begin
    iClk = 1'b0;
    forever #4 iClk = ~iClk;
  end

  // Longest test is under 500 cycles, 2000 leaves margin
  always @(posedge iClk) begin
    cycles <= cycles + 1;
    if (cycles == 2000) begin
      $display("Timeout: DUT did not return ready within 2000 cycles");
      $display("Errors: %0d result, %0d assertion", errors, uut.u_sva.fail_count);
      $display("Regression failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Stimulus tasks
  // ----------------------------------------
  // Inputs change 1 ns after the rising edge
  task automatic step_cycle();
    @(posedge iClk);
    #1;
  endtask

  // Runs one block and checks the ciphertext
  task automatic run_block(input logic kl, input block_t expected, input logic busy_next,
                           input int gap);
    repeat (gap) step_cycle();
    keylen = kl;
    next   = 1'b1;
    step_cycle();
    next   = 1'b0;
    if (busy_next) begin
      // Starts requested mid-run, expected to be ignored
      repeat (3) step_cycle();
      next = 1'b1;
      step_cycle();
      next = 1'b0;
      repeat (10) step_cycle();
      next = 1'b1;
      repeat (2) step_cycle();
      next = 1'b0;
    end
    do begin
      step_cycle();
    end while (!ready);
    assert (new_block === expected)
      else begin
        $display("Fail: new_block = %h, expected %h", new_block, expected);
        errors++;
      end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    void'($urandom(42));
    arst_n = 1'b0;
    next   = 1'b0;
    keylen = 1'b0;
    block  = 128'h00112233445566778899aabbccddeeff;
    repeat (2) @(posedge iClk);
    #1 arst_n = 1'b1;
    // Random idle gaps between starts
    run_block(1'b0, 128'h69c4e0d86a7b0430d8cdb78070b4c55a, 1'b0, $urandom_range(7, 1));
    run_block(1'b1, 128'h8ea2b7ca516745bfeafc49904b496089, 1'b0, $urandom_range(7, 0));
    run_block(1'b0, 128'h69c4e0d86a7b0430d8cdb78070b4c55a, 1'b1, $urandom_range(7, 0));
    run_block(1'b1, 128'h8ea2b7ca516745bfeafc49904b496089, 1'b1, $urandom_range(7, 0));
    // Back to back, alternating key lengths
    run_block(1'b0, 128'h69c4e0d86a7b0430d8cdb78070b4c55a, 1'b0, 0);
    run_block(1'b1, 128'h8ea2b7ca516745bfeafc49904b496089, 1'b0, 0);
    run_block(1'b0, 128'h69c4e0d86a7b0430d8cdb78070b4c55a, 1'b1, 0);
    repeat (3) step_cycle();
    total = errors + int'(uut.u_sva.fail_count);
    $display("Errors: %0d result, %0d assertion", errors, uut.u_sva.fail_count);
    if (total == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- project.f
src/aes_pkg.sv
src/aes_sbox_word.sv
src/aes_mixcolumns.sv
src/aes_round_ctrl.sv
src/aes_round_datapath.sv
src/aes_encipher_core.sv
sim/aes_encipher_sva.sv
sim/tb_aes_encipher.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_aes_encipher
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
